//--- hdl/bus_pkg.sv
package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    TARGET_NONE,
    TARGET_EXT,
    TARGET_CLINT
  } target_e;

  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_FETCH,
    GRANT_LSU
  } grant_e;

  // mtime word offsets from the clint base
  localparam addr_t MTIME_LO_OFFSET = 32'h0000_0048;
  localparam addr_t MTIME_HI_OFFSET = 32'h0000_004c;

  typedef union packed {
    logic [63:0] full;  // counter view
    struct packed {
      data_t hi;
      data_t lo;
    } words;  // bus word view
  } mtime_t;

endpackage

//--- hdl/clint.sv
`timescale 1ns/1ps

module clint import bus_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,

  output logic  rvalid,
  output data_t rdata,
  output resp_t rresp,
  input  logic  rready
);

  mtime_t mtime;
  logic   ar_fire;

  assign arready = !rvalid;  // one read at a time
  assign ar_fire = arvalid && arready;

  // free running, counts from the first cycle after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime.full <= '0;
    end else begin
      mtime.full <= mtime.full + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= araddr[2] ? mtime.words.hi : mtime.words.lo;
      rresp <= RESP_OKAY;
    end
  end

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; #(
  parameter addr_t CLINT_BASE = 32'ha000_0000
) (
  input  logic    clock,
  input  logic    reset,

  input  logic    fetch_arvalid,
  input  addr_t   fetch_araddr,
  input  logic    lsu_arvalid,
  input  addr_t   lsu_araddr,
  input  logic    lsu_awvalid,

  input  logic    done,

  output grant_e  grant,
  output target_e target
);

  logic busy;  // low while idle

  // reads of the two mtime words stay local, the rest goes out
  function automatic target_e read_target(input addr_t addr);
    target_e sel;
    if (addr == CLINT_BASE + MTIME_LO_OFFSET ||
        addr == CLINT_BASE + MTIME_HI_OFFSET) begin
      sel = TARGET_CLINT;
    end else begin
      sel = TARGET_EXT;
    end
    return sel;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      busy   <= 1'b0;
      grant  <= GRANT_NONE;
      target <= TARGET_NONE;
    end else if (!busy) begin
      // fixed priority: fetch read, lsu read, lsu write
      if (fetch_arvalid) begin
        busy   <= 1'b1;
        grant  <= GRANT_FETCH;
        target <= read_target(fetch_araddr);
      end else if (lsu_arvalid) begin
        busy   <= 1'b1;
        grant  <= GRANT_LSU;
        target <= read_target(lsu_araddr);
      end else if (lsu_awvalid) begin
        busy   <= 1'b1;
        grant  <= GRANT_LSU;
        target <= TARGET_EXT;  // clint takes no writes
      end
    end else if (done) begin
      busy   <= 1'b0;
      grant  <= GRANT_NONE;
      target <= TARGET_NONE;
    end
  end

endmodule

//--- hdl/bus_router.sv
`timescale 1ns/1ps

module bus_router import bus_pkg::*; (
  input  grant_e  grant,
  input  target_e target,

  // fetch unit, read only
  input  logic    fetch_arvalid,
  input  addr_t   fetch_araddr,
  output logic    fetch_arready,
  output logic    fetch_rvalid,
  output data_t   fetch_rdata,
  output resp_t   fetch_rresp,
  input  logic    fetch_rready,

  // load/store unit
  input  logic    lsu_arvalid,
  input  addr_t   lsu_araddr,
  output logic    lsu_arready,
  output logic    lsu_rvalid,
  output data_t   lsu_rdata,
  output resp_t   lsu_rresp,
  input  logic    lsu_rready,
  input  logic    lsu_awvalid,
  input  addr_t   lsu_awaddr,
  output logic    lsu_awready,
  input  logic    lsu_wvalid,
  input  data_t   lsu_wdata,
  input  strb_t   lsu_wstrb,
  output logic    lsu_wready,
  output logic    lsu_bvalid,
  output resp_t   lsu_bresp,
  input  logic    lsu_bready,

  // external port
  output logic    ext_arvalid,
  output addr_t   ext_araddr,
  input  logic    ext_arready,
  input  logic    ext_rvalid,
  input  data_t   ext_rdata,
  input  resp_t   ext_rresp,
  output logic    ext_rready,
  output logic    ext_awvalid,
  output addr_t   ext_awaddr,
  input  logic    ext_awready,
  output logic    ext_wvalid,
  output data_t   ext_wdata,
  output strb_t   ext_wstrb,
  input  logic    ext_wready,
  input  logic    ext_bvalid,
  input  resp_t   ext_bresp,
  output logic    ext_bready,

  // clint
  output logic    clint_arvalid,
  output addr_t   clint_araddr,
  input  logic    clint_arready,
  input  logic    clint_rvalid,
  input  data_t   clint_rdata,
  input  resp_t   clint_rresp,
  output logic    clint_rready,

  output logic    done
);

  logic  to_ext, to_clint, wr_sel;
  logic  sel_arvalid, sel_rready;
  addr_t sel_araddr;
  logic  tgt_arready, tgt_rvalid;
  data_t tgt_rdata;
  resp_t tgt_rresp;

  assign to_ext   = (target == TARGET_EXT);
  assign to_clint = (target == TARGET_CLINT);
  assign wr_sel   = (grant == GRANT_LSU) && to_ext;  // only the lsu writes

  // read request of the granted master
  always_comb begin
    sel_arvalid = 1'b0;
    sel_araddr  = '0;
    sel_rready  = 1'b0;
    case (grant)
      GRANT_FETCH: begin
        sel_arvalid = fetch_arvalid;
        sel_araddr  = fetch_araddr;
        sel_rready  = fetch_rready;
      end
      GRANT_LSU: begin
        sel_arvalid = lsu_arvalid;
        sel_araddr  = lsu_araddr;
        sel_rready  = lsu_rready;
      end
      default: ;
    endcase
  end

  assign ext_arvalid = to_ext && sel_arvalid;
  assign ext_araddr  = to_ext ? sel_araddr : '0;
  assign ext_rready  = to_ext && sel_rready;

  assign clint_arvalid = to_clint && sel_arvalid;
  assign clint_araddr  = to_clint ? sel_araddr : '0;
  assign clint_rready  = to_clint && sel_rready;

  assign ext_awvalid = wr_sel && lsu_awvalid;
  assign ext_awaddr  = wr_sel ? lsu_awaddr : '0;
  assign ext_wvalid  = wr_sel && lsu_wvalid;
  assign ext_wdata   = wr_sel ? lsu_wdata : '0;
  assign ext_wstrb   = wr_sel ? lsu_wstrb : '0;
  assign ext_bready  = wr_sel && lsu_bready;

  // read side of the chosen slave
  always_comb begin
    tgt_arready = 1'b0;
    tgt_rvalid  = 1'b0;
    tgt_rdata   = '0;
    tgt_rresp   = RESP_OKAY;
    if (to_ext) begin
      tgt_arready = ext_arready;
      tgt_rvalid  = ext_rvalid;
      tgt_rdata   = ext_rdata;
      tgt_rresp   = ext_rresp;
    end else if (to_clint) begin
      tgt_arready = clint_arready;
      tgt_rvalid  = clint_rvalid;
      tgt_rdata   = clint_rdata;
      tgt_rresp   = clint_rresp;
    end
  end

  assign fetch_arready = (grant == GRANT_FETCH) && tgt_arready;
  assign fetch_rvalid  = (grant == GRANT_FETCH) && tgt_rvalid;
  assign fetch_rdata   = (grant == GRANT_FETCH) ? tgt_rdata : '0;
  assign fetch_rresp   = (grant == GRANT_FETCH) ? tgt_rresp : '0;

  assign lsu_arready = (grant == GRANT_LSU) && tgt_arready;
  assign lsu_rvalid  = (grant == GRANT_LSU) && tgt_rvalid;
  assign lsu_rdata   = (grant == GRANT_LSU) ? tgt_rdata : '0;
  assign lsu_rresp   = (grant == GRANT_LSU) ? tgt_rresp : '0;

  assign lsu_awready = wr_sel && ext_awready;
  assign lsu_wready  = wr_sel && ext_wready;
  assign lsu_bvalid  = wr_sel && ext_bvalid;
  assign lsu_bresp   = wr_sel ? ext_bresp : '0;

  // the lsu keeps one request up at a time, so R and B never overlap
  assign done = (tgt_rvalid && sel_rready) || (lsu_bvalid && lsu_bready);

endmodule

//--- hdl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import bus_pkg::*; #(
  parameter addr_t CLINT_BASE = 32'ha000_0000
) (
  input  logic  clock,
  input  logic  reset,

  input  logic  fetch_arvalid,
  input  addr_t fetch_araddr,
  output logic  fetch_arready,
  output logic  fetch_rvalid,
  output data_t fetch_rdata,
  output resp_t fetch_rresp,
  input  logic  fetch_rready,

  input  logic  lsu_arvalid,
  input  addr_t lsu_araddr,
  output logic  lsu_arready,
  output logic  lsu_rvalid,
  output data_t lsu_rdata,
  output resp_t lsu_rresp,
  input  logic  lsu_rready,
  input  logic  lsu_awvalid,
  input  addr_t lsu_awaddr,
  output logic  lsu_awready,
  input  logic  lsu_wvalid,
  input  data_t lsu_wdata,
  input  strb_t lsu_wstrb,
  output logic  lsu_wready,
  output logic  lsu_bvalid,
  output resp_t lsu_bresp,
  input  logic  lsu_bready,

  output logic  ext_arvalid,
  output addr_t ext_araddr,
  input  logic  ext_arready,
  input  logic  ext_rvalid,
  input  data_t ext_rdata,
  input  resp_t ext_rresp,
  output logic  ext_rready,
  output logic  ext_awvalid,
  output addr_t ext_awaddr,
  input  logic  ext_awready,
  output logic  ext_wvalid,
  output data_t ext_wdata,
  output strb_t ext_wstrb,
  input  logic  ext_wready,
  input  logic  ext_bvalid,
  input  resp_t ext_bresp,
  output logic  ext_bready
);

  grant_e  grant;
  target_e target;
  logic    done;

  logic    clint_arvalid, clint_arready;
  addr_t   clint_araddr;
  logic    clint_rvalid, clint_rready;
  data_t   clint_rdata;
  resp_t   clint_rresp;

  bus_arbiter #(
    .CLINT_BASE(CLINT_BASE)
  ) u_arbiter (
    .clock         (clock),
    .reset         (reset),
    .fetch_arvalid (fetch_arvalid),
    .fetch_araddr  (fetch_araddr),
    .lsu_arvalid   (lsu_arvalid),
    .lsu_araddr    (lsu_araddr),
    .lsu_awvalid   (lsu_awvalid),
    .done          (done),
    .grant         (grant),
    .target        (target)
  );

  bus_router u_router (
    .grant(grant), .target(target),
    .fetch_arvalid(fetch_arvalid), .fetch_araddr(fetch_araddr),
    .fetch_arready(fetch_arready), .fetch_rvalid(fetch_rvalid),
    .fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
    .fetch_rready(fetch_rready),
    .lsu_arvalid(lsu_arvalid), .lsu_araddr(lsu_araddr), .lsu_arready(lsu_arready),
    .lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata), .lsu_rresp(lsu_rresp),
    .lsu_rready(lsu_rready),
    .lsu_awvalid(lsu_awvalid), .lsu_awaddr(lsu_awaddr), .lsu_awready(lsu_awready),
    .lsu_wvalid(lsu_wvalid), .lsu_wdata(lsu_wdata), .lsu_wstrb(lsu_wstrb),
    .lsu_wready(lsu_wready),
    .lsu_bvalid(lsu_bvalid), .lsu_bresp(lsu_bresp), .lsu_bready(lsu_bready),
    .ext_arvalid(ext_arvalid), .ext_araddr(ext_araddr), .ext_arready(ext_arready),
    .ext_rvalid(ext_rvalid), .ext_rdata(ext_rdata), .ext_rresp(ext_rresp),
    .ext_rready(ext_rready),
    .ext_awvalid(ext_awvalid), .ext_awaddr(ext_awaddr), .ext_awready(ext_awready),
    .ext_wvalid(ext_wvalid), .ext_wdata(ext_wdata), .ext_wstrb(ext_wstrb),
    .ext_wready(ext_wready),
    .ext_bvalid(ext_bvalid), .ext_bresp(ext_bresp), .ext_bready(ext_bready),
    .clint_arvalid(clint_arvalid), .clint_araddr(clint_araddr),
    .clint_arready(clint_arready), .clint_rvalid(clint_rvalid),
    .clint_rdata(clint_rdata), .clint_rresp(clint_rresp),
    .clint_rready(clint_rready),
    .done(done)
  );

  // local mtime, read only
  clint u_clint (
    .clock   (clock),
    .reset   (reset),
    .arvalid (clint_arvalid),
    .araddr  (clint_araddr),
    .arready (clint_arready),
    .rvalid  (clint_rvalid),
    .rdata   (clint_rdata),
    .rresp   (clint_rresp),
    .rready  (clint_rready)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clock
);

  initial begin
    clock = 1'b0;
  end

  always #2 clock = ~clock;  // 4 ns period

endmodule

//--- sim/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model import bus_pkg::*; #(
  parameter logic [31:0] SEED = 32'h0000_0001
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,
  output logic  rvalid,
  output data_t rdata,
  output resp_t rresp,
  input  logic  rready,
  input  logic  awvalid,
  input  addr_t awaddr,
  output logic  awready,
  input  logic  wvalid,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  wready,
  output logic  bvalid,
  output resp_t bresp,
  input  logic  bready
);

  data_t       mem [0:255];
  logic [31:0] rng_state;
  logic [31:0] rnd;
  logic [2:0]  rd_st, wr_st;  // 0 idle, 1 delay, 2 accept, 3 delay, 4 respond
  logic [1:0]  rd_cnt, wr_cnt;

  function automatic data_t fill_word(input logic [7:0] idx);
    return {idx ^ 8'ha5, ~idx, idx, idx + 8'h3c};
  endfunction

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  initial begin
    rng_state = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i[7:0]);
    end
  end

  assign rresp = RESP_OKAY;
  assign bresp = RESP_OKAY;

  always @(posedge clock) begin
    rnd = next_rand();
    if (reset) begin
      rd_st   <= 3'd0;
      wr_st   <= 3'd0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      case (rd_st)
        3'd0: if (arvalid) begin
          rd_cnt <= rnd[1:0];
          rd_st  <= 3'd1;
        end
        3'd1: if (rd_cnt == 2'd0) begin
          arready <= 1'b1;
          rd_st   <= 3'd2;
        end else begin
          rd_cnt <= rd_cnt - 2'd1;
        end
        3'd2: begin  // address transfers on this edge
          arready <= 1'b0;
          rdata   <= mem[araddr[9:2]];
          rd_cnt  <= rnd[3:2];
          rd_st   <= 3'd3;
        end
        3'd3: if (rd_cnt == 2'd0) begin
          rvalid <= 1'b1;
          rd_st  <= 3'd4;
        end else begin
          rd_cnt <= rd_cnt - 2'd1;
        end
        default: if (rready) begin
          rvalid <= 1'b0;
          rd_st  <= 3'd0;
        end
      endcase
      case (wr_st)
        3'd0: if (awvalid && wvalid) begin
          wr_cnt <= rnd[5:4];
          wr_st  <= 3'd1;
        end
        3'd1: if (wr_cnt == 2'd0) begin
          awready <= 1'b1;
          wready  <= 1'b1;
          wr_st   <= 3'd2;
        end else begin
          wr_cnt <= wr_cnt - 2'd1;
        end
        3'd2: begin
          awready <= 1'b0;
          wready  <= 1'b0;
          for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) mem[awaddr[9:2]][8*b +: 8] <= wdata[8*b +: 8];
          end
          wr_cnt <= rnd[7:6];
          wr_st  <= 3'd3;
        end
        3'd3: if (wr_cnt == 2'd0) begin
          bvalid <= 1'b1;
          wr_st  <= 3'd4;
        end else begin
          wr_cnt <= wr_cnt - 2'd1;
        end
        default: if (bready) begin
          bvalid <= 1'b0;
          wr_st  <= 3'd0;
        end
      endcase
    end
  end

endmodule

//--- sim/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb import bus_pkg::*; ();

  localparam addr_t CLINT_BASE = 32'ha000_0000;
  localparam logic [31:0] SEED = 32'he388_0e8d;

  logic  clock, reset;
  logic  fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  addr_t fetch_araddr;
  data_t fetch_rdata;
  resp_t fetch_rresp;
  logic  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
  addr_t lsu_araddr, lsu_awaddr;
  data_t lsu_rdata, lsu_wdata;
  resp_t lsu_rresp, lsu_bresp;
  logic  lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
  strb_t lsu_wstrb;
  logic  ext_arvalid, ext_arready, ext_rvalid, ext_rready;
  addr_t ext_araddr, ext_awaddr;
  data_t ext_rdata, ext_wdata;
  resp_t ext_rresp, ext_bresp;
  logic  ext_awvalid, ext_awready, ext_wvalid, ext_wready, ext_bvalid, ext_bready;
  strb_t ext_wstrb;

  logic [31:0] rng_state;
  logic [63:0] cyc;  // tracks mtime
  data_t       shadow [0:255];
  data_t       fetch_exp, lsu_exp;
  int          fetch_open, lsu_open, wr_open;
  logic        race_on, fetch_first, clint_busy;
  logic        any_out;
  addr_t       a, b;
  data_t       d;
  logic [31:0] r;

  tb_clock u_clock (.clock(clock));

  soc_bus_top #(.CLINT_BASE(CLINT_BASE)) UUT (.*);

  ext_mem_model #(.SEED(SEED)) u_mem (
    .clock(clock), .reset(reset),
    .arvalid(ext_arvalid), .araddr(ext_araddr), .arready(ext_arready),
    .rvalid(ext_rvalid), .rdata(ext_rdata), .rresp(ext_rresp), .rready(ext_rready),
    .awvalid(ext_awvalid), .awaddr(ext_awaddr), .awready(ext_awready),
    .wvalid(ext_wvalid), .wdata(ext_wdata), .wstrb(ext_wstrb), .wready(ext_wready),
    .bvalid(ext_bvalid), .bresp(ext_bresp), .bready(ext_bready)
  );

  assign any_out = fetch_arready | fetch_rvalid | lsu_arready | lsu_rvalid | lsu_awready |
                   lsu_wready | lsu_bvalid | ext_arvalid | ext_rready | ext_awvalid |
                   ext_wvalid | ext_bready;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic addr_t ext_addr();
    logic [31:0] x;
    x = next_rand();
    return {22'd0, x[7:0], 2'b00};
  endfunction

  // value a read should return, judged at its address transfer
  function automatic data_t expect_read(input addr_t addr);
    if (addr == CLINT_BASE + MTIME_LO_OFFSET) return cyc[31:0];
    if (addr == CLINT_BASE + MTIME_HI_OFFSET) return cyc[63:32];
    return shadow[addr[9:2]];
  endfunction

  task automatic fail_now(input string msg);
    $display("** Error: %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic set_rready(input bit lsu, input bit v);
    if (lsu) lsu_rready <= v;
    else fetch_rready <= v;
  endtask

  // starts and ends on a rising edge
  task automatic read_txn(input bit lsu, input addr_t addr);
    int n;
    if (lsu) begin
      lsu_arvalid <= 1'b1;
      lsu_araddr  <= addr;
    end else begin
      fetch_arvalid <= 1'b1;
      fetch_araddr  <= addr;
    end
    n = 0;
    forever begin
      @(negedge clock);
      if (lsu ? lsu_arready : fetch_arready) break;
      @(posedge clock);
      n++;
      if (n > 100) timeout_abort("read address ready");
    end
    @(posedge clock);
    if (lsu) lsu_arvalid <= 1'b0;
    else fetch_arvalid <= 1'b0;
    n = 0;
    forever begin
      set_rready(lsu, next_rand() % 3 != 0);  // random back-pressure
      @(negedge clock);
      if (lsu ? (lsu_rvalid && lsu_rready) : (fetch_rvalid && fetch_rready)) break;
      @(posedge clock);
      n++;
      if (n > 100) timeout_abort("read response");
    end
    @(posedge clock);
    set_rready(lsu, 1'b0);
  endtask

  task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb);
    int n;
    lsu_awvalid <= 1'b1;
    lsu_awaddr  <= addr;
    lsu_wvalid  <= 1'b1;
    lsu_wdata   <= data;
    lsu_wstrb   <= strb;
    n = 0;
    forever begin
      @(negedge clock);
      if (lsu_awready && lsu_wready) break;
      @(posedge clock);
      n++;
      if (n > 100) timeout_abort("write address and data ready");
    end
    @(posedge clock);
    lsu_awvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
    n = 0;
    forever begin
      lsu_bready <= next_rand() % 3 != 0;
      @(negedge clock);
      if (lsu_bvalid && lsu_bready) break;
      @(posedge clock);
      n++;
      if (n > 100) timeout_abort("write response");
    end
    @(posedge clock);
    lsu_bready <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) shadow[addr[9:2]][8*i +: 8] = data[8*i +: 8];
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      cyc        <= 64'd0;
      fetch_open <= 0;
      lsu_open   <= 0;
      wr_open    <= 0;
    end else begin
      cyc <= cyc + 64'd1;
      if (fetch_arvalid && fetch_arready) begin
        fetch_exp  <= expect_read(fetch_araddr);
        fetch_open <= fetch_open + 1;
      end else if (fetch_rvalid && fetch_rready) begin
        fetch_open <= fetch_open - 1;
      end
      if (lsu_arvalid && lsu_arready) begin
        lsu_exp  <= expect_read(lsu_araddr);
        lsu_open <= lsu_open + 1;
      end else if (lsu_rvalid && lsu_rready) begin
        lsu_open <= lsu_open - 1;
      end
      if (lsu_awvalid && lsu_awready) wr_open <= wr_open + 1;
      else if (lsu_bvalid && lsu_bready) wr_open <= wr_open - 1;
    end
    if (!race_on) fetch_first <= 1'b0;
    else if (fetch_rvalid && fetch_rready) fetch_first <= 1'b1;
  end

  assert property (@(posedge clock) $past(reset) |-> !any_out)
    else fail_now("ready or valid high during or right after reset");
  assert property (@(posedge clock) disable iff (reset) fetch_rvalid && fetch_rready |->
      fetch_rdata == fetch_exp && fetch_rresp == RESP_OKAY && fetch_open == 1)
    else fail_now("wrong fetch read response");
  assert property (@(posedge clock) disable iff (reset) lsu_rvalid && lsu_rready |->
      lsu_rdata == lsu_exp && lsu_rresp == RESP_OKAY && lsu_open == 1)
    else fail_now("wrong lsu read response");
  assert property (@(posedge clock) disable iff (reset) lsu_bvalid && lsu_bready |->
      lsu_bresp == RESP_OKAY && wr_open == 1)
    else fail_now("wrong lsu write response");
  assert property (@(posedge clock) disable iff (reset)
      fetch_rvalid |-> lsu_open == 0 && wr_open == 0)
    else fail_now("fetch response while lsu holds the bus");
  assert property (@(posedge clock) disable iff (reset) clint_busy |-> !ext_arvalid)
    else fail_now("mtime read leaked to the external port");
  assert property (@(posedge clock) disable iff (reset)
      race_on && lsu_rvalid && lsu_rready |-> fetch_first)
    else fail_now("lsu read finished before the competing fetch read");
  assert property (@(posedge clock) disable iff (reset) fetch_rvalid && !fetch_rready |=>
      fetch_rvalid && $stable(fetch_rdata) && $stable(fetch_rresp))
    else fail_now("held fetch response changed");
  assert property (@(posedge clock) disable iff (reset) lsu_rvalid && !lsu_rready |=>
      lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
    else fail_now("held lsu read response changed");
  assert property (@(posedge clock) disable iff (reset) lsu_bvalid && !lsu_bready |=>
      lsu_bvalid && $stable(lsu_bresp))
    else fail_now("held lsu write response changed");
  assert property (@(posedge clock) disable iff (reset)
      fetch_open != 0 |-> !lsu_arready && !lsu_awready && !lsu_wready)
    else fail_now("lsu accepted while fetch response pending");
  assert property (@(posedge clock) disable iff (reset)
      lsu_open != 0 || wr_open != 0 |-> !fetch_arready)
    else fail_now("fetch accepted while lsu response pending");

  initial begin
    rng_state     = SEED;
    reset         = 1'b1;
    fetch_arvalid = 1'b1;  // requests up during reset, must be ignored
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    lsu_arvalid   = 1'b1;
    lsu_araddr    = '0;
    lsu_rready    = 1'b0;
    lsu_awvalid   = 1'b1;
    lsu_awaddr    = '0;
    lsu_wvalid    = 1'b1;
    lsu_wdata     = '0;
    lsu_wstrb     = '0;
    lsu_bready    = 1'b0;
    race_on       = 1'b0;
    clint_busy    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = {i[7:0] ^ 8'ha5, ~i[7:0], i[7:0], i[7:0] + 8'h3c};  // same fill as the model
    end
    repeat (4) @(posedge clock);
    reset         <= 1'b0;
    fetch_arvalid <= 1'b0;
    lsu_arvalid   <= 1'b0;
    lsu_awvalid   <= 1'b0;
    lsu_wvalid    <= 1'b0;
    repeat (2) @(posedge clock);

    repeat (8) read_txn(1'b0, ext_addr());

    repeat (8) begin
      a = ext_addr();
      d = next_rand();
      r = next_rand();
      write_txn(a, d, r[3:0]);
      read_txn(1'b1, a);
    end

    clint_busy <= 1'b1;
    fork
      read_txn(1'b1, CLINT_BASE + MTIME_LO_OFFSET);
      begin
        @(posedge clock);  // fetch asks while the lsu read is under way
        read_txn(1'b0, CLINT_BASE + MTIME_LO_OFFSET);
      end
    join
    read_txn(1'b1, CLINT_BASE + MTIME_HI_OFFSET);
    read_txn(1'b0, CLINT_BASE + MTIME_HI_OFFSET);
    clint_busy <= 1'b0;

    for (int k = 0; k < 6; k++) begin
      a = ext_addr();
      b = k[0] ? CLINT_BASE + MTIME_LO_OFFSET : ext_addr();
      race_on <= 1'b1;
      fork
        read_txn(1'b0, a);
        read_txn(1'b1, b);
      join
      race_on <= 1'b0;
      @(posedge clock);
    end

    repeat (4) @(posedge clock);
    if (fetch_open == 0 && lsu_open == 0 && wr_open == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_now("transaction left without a response");
    end
  end

endmodule

//--- filelist.f
hdl/bus_pkg.sv
hdl/clint.sv
hdl/bus_arbiter.sv
hdl/bus_router.sv
hdl/soc_bus_top.sv
sim/tb_clock.sv
sim/ext_mem_model.sv
sim/soc_bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module soc_bus_tb -o soc_bus_sim

out=$(./obj_dir/soc_bus_sim)
echo "$out"
grep -qx "TEST OK" <<< "$out"
